/* battle_overlay.f */
hw/battle_pkg.sv
hw/battle_regs.sv
hw/sprite_addr_gen.sv
hw/hp_bar.sv
hw/pixel_mux.sv
hw/battle_overlay.sv
testbench/battle_overlay_assert.sv
testbench/tb_battle_overlay.sv

/* hw/battle_overlay.sv */
// two-stage overlay pipeline, output two cycles after pixel_in; no stall, one pixel per clock
`timescale 1ns/1ps

module battle_overlay (
   input  logic                   Clk,
   input  logic                   reset,
   input  battle_pkg::apb_req_t   apb_req,
   output battle_pkg::apb_rsp_t   apb_rsp,
   input  battle_pkg::pixel_pos_t pixel_in,
   output battle_pkg::pixel_out_t pixel_out
);
   import battle_pkg::*;

   scene_cfg_t  scene_cfg;
   sprite_hit_t team_hit;
   sprite_hit_t enemy_hit;
   hp_hit_t     my_bar;
   hp_hit_t     enemy_bar;
   logic        stage1_valid;   // all four stages agree, team one is used

   battle_regs u_regs (
      .Clk       (Clk),
      .reset     (reset),
      .apb_req   (apb_req),
      .apb_rsp   (apb_rsp),
      .scene_cfg (scene_cfg)
   );

   sprite_addr_gen #(.ORIGIN_X(TEAM_X), .ORIGIN_Y(TEAM_Y), .FACING(FACE_BACK)) u_team_sprite (
      .Clk       (Clk),
      .reset     (reset),
      .pixel_in  (pixel_in),
      .poke_id   (scene_cfg.team_id),
      .valid_out (stage1_valid),
      .sprite    (team_hit)
   );

   sprite_addr_gen #(.ORIGIN_X(ENEMY_X), .ORIGIN_Y(ENEMY_Y), .FACING(FACE_FRONT)) u_enemy_sprite (
      .Clk       (Clk),
      .reset     (reset),
      .pixel_in  (pixel_in),
      .poke_id   (scene_cfg.enemy_id),
      .valid_out (),
      .sprite    (enemy_hit)
   );

   hp_bar #(.ORIGIN_X(MY_HPBAR_X), .ORIGIN_Y(MY_HPBAR_Y)) u_my_bar (
      .Clk       (Clk),
      .reset     (reset),
      .pixel_in  (pixel_in),
      .max_hp    (scene_cfg.my_max),
      .cur_hp    (scene_cfg.my_cur),
      .valid_out (),
      .bar       (my_bar)
   );

   hp_bar #(.ORIGIN_X(ENEMY_HPBAR_X), .ORIGIN_Y(ENEMY_HPBAR_Y)) u_enemy_bar (
      .Clk       (Clk),
      .reset     (reset),
      .pixel_in  (pixel_in),
      .max_hp    (scene_cfg.enemy_max),
      .cur_hp    (scene_cfg.enemy_cur),
      .valid_out (),
      .bar       (enemy_bar)
   );

   pixel_mux u_mux (
      .Clk       (Clk),
      .reset     (reset),
      .valid     (stage1_valid),
      .team      (team_hit),
      .enemy     (enemy_hit),
      .my_bar    (my_bar),
      .enemy_bar (enemy_bar),
      .pixel_out (pixel_out)
   );

endmodule

/* hw/battle_pkg.sv */
// geometry assumes a 640x480 raster; sheet holds 8 ids as 4 rows of back/front pairs, no text layer
package battle_pkg;

   typedef logic [9:0]  coord_t;
   typedef logic [2:0]  poke_id_t;
   typedef logic [7:0]  hp_t;
   typedef logic [18:0] sheet_addr_t;
   typedef logic [7:0]  color_t;
   typedef logic [2:0]  layer_t;

   // winning layer codes
   localparam layer_t LAYER_NONE         = 3'd0;
   localparam layer_t LAYER_HP_BORDER    = 3'd1;
   localparam layer_t LAYER_HP_FILL      = 3'd2;
   localparam layer_t LAYER_TEAM_SPRITE  = 3'd3;
   localparam layer_t LAYER_ENEMY_SPRITE = 3'd4;

   localparam int SPRITE_W = 56;
   localparam int SPRITE_H = 56;
   localparam int SHEET_W  = 224;   // four sprite columns

   localparam coord_t TEAM_X  = 10'd250;
   localparam coord_t TEAM_Y  = 10'd290;
   localparam coord_t ENEMY_X = 10'd410;
   localparam coord_t ENEMY_Y = 10'd160;

   localparam logic FACE_BACK  = 1'b0;
   localparam logic FACE_FRONT = 1'b1;

   localparam int HPBAR_W = 50;
   localparam int HPBAR_H = 5;

   localparam coord_t MY_HPBAR_X    = 10'd400;
   localparam coord_t MY_HPBAR_Y    = 10'd330;
   localparam coord_t ENEMY_HPBAR_X = 10'd120;
   localparam coord_t ENEMY_HPBAR_Y = 10'd60;

   typedef struct packed {
      color_t r;
      color_t g;
      color_t b;
   } rgb_t;

   localparam rgb_t COLOR_BORDER = rgb_t'{8'h00, 8'h00, 8'h00};
   localparam rgb_t COLOR_HIGH   = rgb_t'{8'h41, 8'hff, 8'h74};   // green
   localparam rgb_t COLOR_MID    = rgb_t'{8'hff, 8'hae, 8'h42};   // orange
   localparam rgb_t COLOR_LOW    = rgb_t'{8'hff, 8'h33, 8'h00};   // red

   // register offsets
   localparam logic [3:0] REG_IDS      = 4'h0;
   localparam logic [3:0] REG_MY_HP    = 4'h4;
   localparam logic [3:0] REG_ENEMY_HP = 4'h8;

   typedef struct packed {
      logic   valid;
      coord_t x;
      coord_t y;
   } pixel_pos_t;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [3:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   typedef struct packed {
      poke_id_t team_id;
      poke_id_t enemy_id;
      hp_t      my_max;
      hp_t      my_cur;
      hp_t      enemy_max;
      hp_t      enemy_cur;
   } scene_cfg_t;

   typedef struct packed {
      logic        hit;
      sheet_addr_t addr;
   } sprite_hit_t;

   typedef struct packed {
      logic border;
      logic fill;
      rgb_t color;
   } hp_hit_t;

   typedef struct packed {
      logic        valid;
      layer_t      layer;
      sheet_addr_t sprite_addr;
      rgb_t        color;
   } pixel_out_t;

endpackage

/* hw/battle_regs.sv */
// zero-wait APB slave, 4-bit word offsets; unmapped offsets flag pslverr and ignore writes
`timescale 1ns/1ps

module battle_regs (
   input  logic                   Clk,
   input  logic                   reset,
   input  battle_pkg::apb_req_t   apb_req,
   output battle_pkg::apb_rsp_t   apb_rsp,
   output battle_pkg::scene_cfg_t scene_cfg
);
   import battle_pkg::*;

   scene_cfg_t  cfg;
   logic        access;
   logic        mapped;
   logic [31:0] rd_word;

   assign access = apb_req.psel & apb_req.penable;

   // decode and read mux
   always_comb begin
      mapped  = 1'b1;
      rd_word = '0;
      case (apb_req.paddr)
         REG_IDS: begin
            rd_word[2:0] = cfg.team_id;
            rd_word[6:4] = cfg.enemy_id;
         end
         REG_MY_HP: begin
            rd_word[15:8] = cfg.my_max;
            rd_word[7:0]  = cfg.my_cur;
         end
         REG_ENEMY_HP: begin
            rd_word[15:8] = cfg.enemy_max;
            rd_word[7:0]  = cfg.enemy_cur;
         end
         default: mapped = 1'b0;
      endcase
   end

   always_ff @(posedge Clk) begin
      if (reset) begin
         cfg <= '0;
      end else if (access && apb_req.pwrite && mapped) begin
         case (apb_req.paddr)
            REG_IDS: begin
               cfg.team_id  <= apb_req.pwdata[2:0];
               cfg.enemy_id <= apb_req.pwdata[6:4];
            end
            REG_MY_HP: begin
               cfg.my_max <= apb_req.pwdata[15:8];
               cfg.my_cur <= apb_req.pwdata[7:0];
            end
            default: begin   // enemy hp, only mapped offset left
               cfg.enemy_max <= apb_req.pwdata[15:8];
               cfg.enemy_cur <= apb_req.pwdata[7:0];
            end
         endcase
      end
   end

   // read data only while a read is in its access phase
   assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_word : 32'd0;
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access & ~mapped;

   assign scene_cfg = cfg;

endmodule

/* hw/hp_bar.sv */
// one 50x5 HP bar with a 1-pixel frame; fill width lags the HP registers by one cycle
`timescale 1ns/1ps

module hp_bar #(
   parameter battle_pkg::coord_t ORIGIN_X = battle_pkg::MY_HPBAR_X,
   parameter battle_pkg::coord_t ORIGIN_Y = battle_pkg::MY_HPBAR_Y
) (
   input  logic                   Clk,
   input  logic                   reset,
   input  battle_pkg::pixel_pos_t pixel_in,
   input  battle_pkg::hp_t        max_hp,
   input  battle_pkg::hp_t        cur_hp,
   output logic                   valid_out,
   output battle_pkg::hp_hit_t    bar
);
   import battle_pkg::*;

   // frame corners
   localparam int BX_L = int'(ORIGIN_X) - 1;
   localparam int BX_R = BX_L + HPBAR_W + 1;
   localparam int BY_T = int'(ORIGIN_Y) - 1;
   localparam int BY_B = BY_T + HPBAR_H + 1;

   logic [13:0] scaled;   // 50 * cur, at most 12750
   logic [5:0]  fill_w_next;
   logic [5:0]  fill_w;
   coord_t      dx;
   logic        in_frame_x;
   logic        in_frame_y;
   logic        border_c;
   logic        fill_c;
   rgb_t        fill_color;
   rgb_t        color_c;

   assign scaled = 14'(cur_hp) * 14'(HPBAR_W);

   always_comb begin
      if (max_hp == '0) begin
         fill_w_next = '0;
      end else if (cur_hp == max_hp) begin
         fill_w_next = 6'(HPBAR_W);
      end else begin
         fill_w_next = 6'((scaled / 14'(max_hp)) % 14'(HPBAR_W));
      end
   end

   assign dx = pixel_in.x - ORIGIN_X;

   always_comb begin
      in_frame_x = int'(pixel_in.x) >= BX_L && int'(pixel_in.x) <= BX_R;
      in_frame_y = int'(pixel_in.y) >= BY_T && int'(pixel_in.y) <= BY_B;
      border_c   = pixel_in.valid
                 && ((in_frame_x && (int'(pixel_in.y) == BY_T || int'(pixel_in.y) == BY_B))
                 ||  (in_frame_y && (int'(pixel_in.x) == BX_L || int'(pixel_in.x) == BX_R)));
      fill_c     = pixel_in.valid
                 && pixel_in.x >= ORIGIN_X && dx < coord_t'(fill_w)
                 && pixel_in.y >= ORIGIN_Y && int'(pixel_in.y) < int'(ORIGIN_Y) + HPBAR_H;

      // thresholds at half and one fifth of the bar
      if (int'(fill_w) * 2 > HPBAR_W) begin
         fill_color = COLOR_HIGH;
      end else if (int'(fill_w) * 5 > HPBAR_W) begin
         fill_color = COLOR_MID;
      end else begin
         fill_color = COLOR_LOW;
      end

      if (fill_c) begin
         color_c = fill_color;
      end else begin
         color_c = '0;
      end
   end

   always_ff @(posedge Clk) begin
      if (reset) begin
         fill_w     <= '0;
         valid_out  <= 1'b0;
         bar.border <= 1'b0;
         bar.fill   <= 1'b0;
      end else begin
         fill_w     <= fill_w_next;
         valid_out  <= pixel_in.valid;
         bar.border <= border_c;
         bar.fill   <= fill_c;
      end
      bar.color <= color_c;
   end

endmodule

/* hw/pixel_mux.sv */
// fixed priority border > fill > team > enemy; sprites carry an address, HP layers a color
`timescale 1ns/1ps

module pixel_mux (
   input  logic                    Clk,
   input  logic                    reset,
   input  logic                    valid,
   input  battle_pkg::sprite_hit_t team,
   input  battle_pkg::sprite_hit_t enemy,
   input  battle_pkg::hp_hit_t     my_bar,
   input  battle_pkg::hp_hit_t     enemy_bar,
   output battle_pkg::pixel_out_t  pixel_out
);
   import battle_pkg::*;

   pixel_out_t next;

   always_comb begin
      next       = '0;
      next.valid = valid;
      if (my_bar.border || enemy_bar.border) begin
         next.layer = LAYER_HP_BORDER;
         next.color = COLOR_BORDER;
      end else if (my_bar.fill) begin
         next.layer = LAYER_HP_FILL;
         next.color = my_bar.color;
      end else if (enemy_bar.fill) begin
         next.layer = LAYER_HP_FILL;
         next.color = enemy_bar.color;
      end else if (team.hit) begin
         next.layer       = LAYER_TEAM_SPRITE;
         next.sprite_addr = team.addr;
      end else if (enemy.hit) begin
         next.layer       = LAYER_ENEMY_SPRITE;
         next.sprite_addr = enemy.addr;
      end else begin
         next.layer = LAYER_NONE;   // color and address stay zero
      end
   end

   always_ff @(posedge Clk) begin
      if (reset) begin
         pixel_out <= '0;
      end else begin
         pixel_out <= next;
      end
   end

endmodule

/* hw/sprite_addr_gen.sv */
// one 56x56 sprite box at a fixed origin; sheet is 224 wide, id picks row and column pair
`timescale 1ns/1ps

module sprite_addr_gen #(
   parameter battle_pkg::coord_t ORIGIN_X = battle_pkg::TEAM_X,
   parameter battle_pkg::coord_t ORIGIN_Y = battle_pkg::TEAM_Y,
   parameter logic               FACING   = battle_pkg::FACE_BACK
) (
   input  logic                    Clk,
   input  logic                    reset,
   input  battle_pkg::pixel_pos_t  pixel_in,
   input  battle_pkg::poke_id_t    poke_id,
   output logic                    valid_out,
   output battle_pkg::sprite_hit_t sprite
);
   import battle_pkg::*;

   coord_t      dx;
   coord_t      dy;
   logic [1:0]  col;   // odd ids sit two columns right
   logic [1:0]  row;
   logic        hit_c;
   sheet_addr_t addr_c;

   assign dx  = pixel_in.x - ORIGIN_X;
   assign dy  = pixel_in.y - ORIGIN_Y;
   assign col = {poke_id[0], FACING};
   assign row = poke_id[2:1];

   always_comb begin
      hit_c = pixel_in.valid
            && pixel_in.x >= ORIGIN_X && int'(dx) < SPRITE_W
            && pixel_in.y >= ORIGIN_Y && int'(dy) < SPRITE_H;
      if (hit_c) begin
         addr_c = sheet_addr_t'(int'(col) * SPRITE_W + int'(dx)
                  + SHEET_W * (int'(row) * SPRITE_H + int'(dy)));
      end else begin
         addr_c = '0;
      end
   end

   always_ff @(posedge Clk) begin
      if (reset) begin
         valid_out  <= 1'b0;
         sprite.hit <= 1'b0;
      end else begin
         valid_out  <= pixel_in.valid;
         sprite.hit <= hit_c;
      end
      sprite.addr <= addr_c;
   end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the battle overlay testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_battle_overlay \
   -Mdir obj_dir \
   -f battle_overlay.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

# let the testbench decide how to end after an assertion fires
sim_out=$(./obj_dir/Vtb_battle_overlay +verilator+error+limit+1000 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulator returned status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
   exit 0
fi
echo "pass message not found"
exit 1

/* testbench/battle_overlay_assert.sv */
// reference model assumes registers change only while no pixel is in flight; fails counted for tb
`timescale 1ns/1ps

module battle_overlay_assert (
   input logic                   Clk,
   input logic                   reset,
   input battle_pkg::apb_req_t   apb_req,
   input battle_pkg::apb_rsp_t   apb_rsp,
   input battle_pkg::pixel_pos_t pixel_in,
   input battle_pkg::pixel_out_t pixel_out
);
   import battle_pkg::*;

   scene_cfg_t  cfg_m;
   pixel_pos_t  p1;
   pixel_pos_t  p2;
   pixel_out_t  exp_out;
   logic        access;
   logic        mapped;
   logic [31:0] exp_rd;
   int          fails = 0;

   assign access = apb_req.psel & apb_req.penable;
   assign mapped = apb_req.paddr == 4'h0 || apb_req.paddr == 4'h4 || apb_req.paddr == 4'h8;

   always_comb begin
      exp_rd = 32'd0;
      case (apb_req.paddr)
         4'h0: exp_rd = {25'd0, cfg_m.enemy_id, 1'b0, cfg_m.team_id};
         4'h4: exp_rd = {16'd0, cfg_m.my_max, cfg_m.my_cur};
         4'h8: exp_rd = {16'd0, cfg_m.enemy_max, cfg_m.enemy_cur};
         default: exp_rd = 32'd0;
      endcase
   end

   always_ff @(posedge Clk) begin
      if (reset) begin
         cfg_m <= '0;
         p1    <= '0;
         p2    <= '0;
      end else begin
         p1 <= pixel_in;
         p2 <= p1;
         if (access && apb_req.pwrite) begin
            if (apb_req.paddr == 4'h0) begin
               cfg_m.team_id  <= apb_req.pwdata[2:0];
               cfg_m.enemy_id <= apb_req.pwdata[6:4];
            end else if (apb_req.paddr == 4'h4) begin
               {cfg_m.my_max, cfg_m.my_cur} <= apb_req.pwdata[15:0];
            end else if (apb_req.paddr == 4'h8) begin
               {cfg_m.enemy_max, cfg_m.enemy_cur} <= apb_req.pwdata[15:0];
            end
         end
      end
   end

   function automatic int fill_len(hp_t mx, hp_t cur);
      if (mx == 0) return 0;
      if (cur == mx) return 50;
      return (50 * int'(cur) / int'(mx)) % 50;
   endfunction

   function automatic rgb_t bar_color(int w);
      if (2 * w > 50) return COLOR_HIGH;
      if (5 * w > 50) return COLOR_MID;
      return COLOR_LOW;
   endfunction

   function automatic logic on_frame(int x, int y, int ox, int oy);
      logic in_box;
      in_box = x >= ox - 1 && x <= ox + 50 && y >= oy - 1 && y <= oy + 5;
      return in_box && (x == ox - 1 || x == ox + 50 || y == oy - 1 || y == oy + 5);
   endfunction

   function automatic logic in_rect(int x, int y, int ox, int oy, int w, int h);
      return x >= ox && x < ox + w && y >= oy && y < oy + h;
   endfunction

   function automatic int sheet_addr(int x, int y, int ox, int oy, int id, int face);
      int col;
      int row;
      col = 2 * (id % 2) + face;
      row = id / 2;
      return col * 56 + (x - ox) + 224 * (row * 56 + (y - oy));
   endfunction

   function automatic pixel_out_t expect_pixel(pixel_pos_t p, scene_cfg_t c);
      pixel_out_t o;
      int x;
      int y;
      int my_w;
      int en_w;
      o    = '0;
      x    = int'(p.x);
      y    = int'(p.y);
      my_w = fill_len(c.my_max, c.my_cur);
      en_w = fill_len(c.enemy_max, c.enemy_cur);
      if (!p.valid) return o;
      o.valid = 1'b1;
      if (on_frame(x, y, 400, 330) || on_frame(x, y, 120, 60)) begin
         o.layer = LAYER_HP_BORDER;
      end else if (in_rect(x, y, 400, 330, my_w, 5)) begin
         o.layer = LAYER_HP_FILL;
         o.color = bar_color(my_w);
      end else if (in_rect(x, y, 120, 60, en_w, 5)) begin
         o.layer = LAYER_HP_FILL;
         o.color = bar_color(en_w);
      end else if (in_rect(x, y, 250, 290, 56, 56)) begin
         o.layer       = LAYER_TEAM_SPRITE;
         o.sprite_addr = sheet_addr_t'(sheet_addr(x, y, 250, 290, int'(c.team_id), 0));
      end else if (in_rect(x, y, 410, 160, 56, 56)) begin
         o.layer       = LAYER_ENEMY_SPRITE;
         o.sprite_addr = sheet_addr_t'(sheet_addr(x, y, 410, 160, int'(c.enemy_id), 1));
      end
      return o;
   endfunction

   assign exp_out = expect_pixel(p2, cfg_m);

   a_pixel: assert property (@(posedge Clk) disable iff (reset) pixel_out == exp_out)
      else begin
         fails++;
         $error("mismatch pixel_out exp %h got %h", exp_out, pixel_out);
      end

   a_reset_quiet: assert property (@(posedge Clk) reset |=> !pixel_out.valid)
      else begin
         fails++;
         $error("mismatch pixel_out.valid exp %h got %h", 1'b0, pixel_out.valid);
      end

   a_after_reset: assert property (@(posedge Clk)
         $fell(reset) |-> !pixel_out.valid ##1 !pixel_out.valid)
      else begin
         fails++;
         $error("pixel_out.valid went high within two cycles after reset");
      end

   a_read: assert property (@(posedge Clk) disable iff (reset)
         access && !apb_req.pwrite && mapped |-> apb_rsp.prdata == exp_rd)
      else begin
         fails++;
         $error("mismatch prdata exp %h got %h", exp_rd, apb_rsp.prdata);
      end

   a_slverr: assert property (@(posedge Clk) disable iff (reset)
         access |-> apb_rsp.pslverr == !mapped && apb_rsp.pready)
      else begin
         fails++;
         $error("mismatch pslverr exp %h got %h", !mapped, apb_rsp.pslverr);
      end

endmodule

bind battle_overlay battle_overlay_assert u_chk (
   .Clk       (Clk),
   .reset     (reset),
   .apb_req   (apb_req),
   .apb_rsp   (apb_rsp),
   .pixel_in  (pixel_in),
   .pixel_out (pixel_out)
);

/* testbench/tb_battle_overlay.sv */
// stimulus only; bound checker does all comparisons, registers written while no pixel is valid
`timescale 1ns/1ps

module tb_battle_overlay;
   import battle_pkg::*;

   localparam int CLK_PERIOD  = 20;
   localparam int APB_ROUNDS  = 20;
   localparam int HP_ROUNDS   = 30;
   localparam int RAND_PIX    = 1000;
   localparam int SWEEP_PIX   = 8 * 2 * 58 * 58 + HP_ROUNDS * 2 * 54 * 9 + RAND_PIX;
   localparam int APB_XFERS   = APB_ROUNDS * 6 + 5 + 8 + HP_ROUNDS * 2;
   localparam int APB_CYCLES  = APB_XFERS * 7 + 8 * 2 * 4 + HP_ROUNDS * 2 * 4;
   localparam int WATCH_LIMIT = (SWEEP_PIX + APB_CYCLES + 16) * 2;

   logic        Clk;
   logic        reset;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   pixel_pos_t  pixel_in;
   pixel_out_t  pixel_out;
   logic [31:0] rng_state = 32'd17;

   battle_overlay u_dut (
      .Clk       (Clk),
      .reset     (reset),
      .apb_req   (apb_req),
      .apb_rsp   (apb_rsp),
      .pixel_in  (pixel_in),
      .pixel_out (pixel_out)
   );

   initial begin
      Clk = 1'b0;
      forever #(CLK_PERIOD / 2) Clk = ~Clk;
   end

   function automatic logic [31:0] xorshift32(logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r = rng_state;
   endtask

   task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data);
      @(posedge Clk);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
      @(posedge Clk);
      apb_req.penable <= 1'b1;
      @(posedge Clk);
      while (!apb_rsp.pready) @(posedge Clk);
      apb_req <= '0;
   endtask

   task automatic settle();
      repeat (4) @(posedge Clk);   // pixels drained, fill width caught up
   endtask

   task automatic sweep_area(input int x0, input int y0, input int w, input int h);
      for (int y = y0; y < y0 + h; y++) begin
         for (int x = x0; x < x0 + w; x++) begin
            @(posedge Clk);
            pixel_in <= '{valid: 1'b1, x: coord_t'(x), y: coord_t'(y)};
         end
      end
      @(posedge Clk);
      pixel_in <= '0;
      settle();
   endtask

   initial begin
      repeat (WATCH_LIMIT) @(posedge Clk);
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired before the tests finished");
   end

   // checker counts assertion failures, stop at the first one
   always @(posedge Clk) begin
      if (u_dut.u_chk.fails != 0) begin
         $display("SIMULATION FAILED");
         $fatal(1, "assertion failure in bound checker");
      end
   end

   initial begin
      logic [31:0] r;
      logic [7:0]  cur;
      logic [7:0]  mx;
      reset    = 1'b1;
      apb_req  = '0;
      pixel_in = '{valid: 1'b1, x: TEAM_X + 10'd5, y: TEAM_Y + 10'd3};   // live through reset
      repeat (16) @(posedge Clk);
      reset <= 1'b0;
      repeat (4) @(posedge Clk);
      pixel_in <= '0;
      settle();

      // register round trip, then the unmapped offset
      for (int i = 0; i < APB_ROUNDS; i++) begin
         next_rand(r);
         apb_xfer(1'b1, REG_IDS, r);
         next_rand(r);
         apb_xfer(1'b1, REG_MY_HP, r);
         next_rand(r);
         apb_xfer(1'b1, REG_ENEMY_HP, r);
         apb_xfer(1'b0, REG_IDS, '0);
         apb_xfer(1'b0, REG_MY_HP, '0);
         apb_xfer(1'b0, REG_ENEMY_HP, '0);
      end
      next_rand(r);
      apb_xfer(1'b1, 4'hc, r);
      apb_xfer(1'b0, 4'hc, '0);
      apb_xfer(1'b0, REG_IDS, '0);
      apb_xfer(1'b0, REG_MY_HP, '0);
      apb_xfer(1'b0, REG_ENEMY_HP, '0);
      settle();

      // every id in both sprite boxes plus margin
      for (int id = 0; id < 8; id++) begin
         apb_xfer(1'b1, REG_IDS, {25'd0, 3'(7 - id), 1'b0, 3'(id)});
         settle();
         sweep_area(int'(TEAM_X) - 1, int'(TEAM_Y) - 1, SPRITE_W + 2, SPRITE_H + 2);
         sweep_area(int'(ENEMY_X) - 1, int'(ENEMY_Y) - 1, SPRITE_W + 2, SPRITE_H + 2);
      end

      // hp fill, color and frame, corner cases first
      for (int i = 0; i < HP_ROUNDS; i++) begin
         next_rand(r);
         cur = r[7:0];
         mx  = r[15:8];
         if (i == 0) cur = mx;
         if (i == 1) mx = 8'd0;
         if (i == 2) cur = 8'd0;
         apb_xfer(1'b1, REG_MY_HP, {16'd0, mx, cur});
         apb_xfer(1'b1, REG_ENEMY_HP, {16'd0, r[23:16], r[31:24]});
         settle();
         sweep_area(int'(MY_HPBAR_X) - 2, int'(MY_HPBAR_Y) - 2, HPBAR_W + 4, HPBAR_H + 4);
         sweep_area(int'(ENEMY_HPBAR_X) - 2, int'(ENEMY_HPBAR_Y) - 2, HPBAR_W + 4, HPBAR_H + 4);
      end

      // random stream with gaps in valid
      for (int i = 0; i < RAND_PIX; i++) begin
         next_rand(r);
         @(posedge Clk);
         pixel_in <= '{valid: r[0], x: coord_t'(r[18:9] % 640), y: coord_t'(r[28:19] % 480)};
      end
      @(posedge Clk);
      pixel_in <= '0;
      settle();

      if (u_dut.u_chk.fails != 0) begin
         $display("SIMULATION FAILED");
         $fatal(1, "assertion failure in bound checker");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule
